// ==== compile.f ====
design/hdc_pkg.sv
design/axil_regs.sv
design/item_gen.sv
design/hdc_core.sv
design/stream_ctrl.sv
design/hdc_top.sv
testbench/tb_hdc_top.sv

// ==== design/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs (
    input  logic                        AXIS_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic [31:0]                 S_AXI_AWADDR,
    input  logic                        S_AXI_AWVALID,
    output logic                        S_AXI_AWREADY,
    input  logic [31:0]                 S_AXI_WDATA,
    input  logic [3:0]                  S_AXI_WSTRB,
    input  logic                        S_AXI_WVALID,
    output logic                        S_AXI_WREADY,
    input  logic                        S_AXI_BREADY,
    output logic [1:0]                  S_AXI_BRESP,
    output logic                        S_AXI_BVALID,
    input  logic [31:0]                 S_AXI_ARADDR,
    input  logic                        S_AXI_ARVALID,
    output logic                        S_AXI_ARREADY,
    input  logic                        S_AXI_RREADY,
    output logic [31:0]                 S_AXI_RDATA,
    output logic [1:0]                  S_AXI_RRESP,
    output logic                        S_AXI_RVALID,
    input  logic                        gen_done,
    output logic                        run,
    output logic                        gen,
    output logic [hdc_pkg::ADDR_W-1:0]  item_memory_num
);
    import hdc_pkg::*;

    // slave states
    localparam logic [2:0] ST_IDLE = 3'd0;
    // address taken, data pending
    localparam logic [2:0] ST_AW   = 3'd1;
    // data taken, address pending
    localparam logic [2:0] ST_W    = 3'd2;
    // both taken, response out
    localparam logic [2:0] ST_AWW  = 3'd3;
    // read data being fetched
    localparam logic [2:0] ST_AR1  = 3'd4;
    // read data out
    localparam logic [2:0] ST_AR2  = 3'd5;

    logic [2:0]             state;
    logic [AXIL_OFFS_W-1:2] wr_addr;
    logic [AXIL_OFFS_W-1:2] rd_addr;
    logic [31:0]            wr_data;
    logic [3:0]             wr_strb;
    logic                   wr_go;
    logic [AXIL_OFFS_W-1:0] wr_offs;
    logic [AXIL_OFFS_W-1:0] rd_offs;

    assign wr_offs = {wr_addr, 2'b00};
    assign rd_offs = {rd_addr, 2'b00};

    // ---------------------------------------------------------
    // handshake
    // ---------------------------------------------------------

    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_W);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_AW);
    // a read waits while a write is offered in idle
    assign S_AXI_ARREADY = (state == ST_IDLE) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == ST_AWW);
    assign S_AXI_RVALID  = (state == ST_AR2);
    // always OKAY
    assign S_AXI_BRESP   = 2'b00;
    assign S_AXI_RRESP   = 2'b00;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
            wr_go <= 1'b0;
        end else begin
            // one-cycle strobe on entering ST_AWW
            wr_go <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= ST_AWW;
                        wr_go <= 1'b1;
                    end else if (S_AXI_AWVALID) begin
                        state <= ST_AW;
                    end else if (S_AXI_WVALID) begin
                        state <= ST_W;
                    end else if (S_AXI_ARVALID) begin
                        state <= ST_AR1;
                    end
                end
                ST_AW: begin
                    if (S_AXI_WVALID) begin
                        state <= ST_AWW;
                        wr_go <= 1'b1;
                    end
                end
                ST_W: begin
                    if (S_AXI_AWVALID) begin
                        state <= ST_AWW;
                        wr_go <= 1'b1;
                    end
                end
                ST_AWW: begin
                    if (S_AXI_BREADY) begin
                        state <= ST_IDLE;
                    end
                end
                // rdata is loaded here
                ST_AR1: state <= ST_AR2;
                ST_AR2: begin
                    if (S_AXI_RREADY) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address and data capture on each handshake
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            wr_addr <= S_AXI_AWADDR[AXIL_OFFS_W-1:2];
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wr_data <= S_AXI_WDATA;
            wr_strb <= S_AXI_WSTRB;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            rd_addr <= S_AXI_ARADDR[AXIL_OFFS_W-1:2];
        end
    end

    // ---------------------------------------------------------
    // registers
    // ---------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run             <= 1'b0;
            gen             <= 1'b0;
            item_memory_num <= '0;
        end else begin
            // generation finished
            if (gen_done) begin
                gen <= 1'b0;
            end
            // a ctrl write in the same cycle wins over gen_done
            if (wr_go && wr_offs == REG_CTRL && wr_strb[0]) begin
                run <= wr_data[1];
                gen <= wr_data[0];
            end
            if (wr_go && wr_offs == REG_ITEM_NUM) begin
                if (wr_strb[0]) begin
                    item_memory_num[7:0] <= wr_data[7:0];
                end
                if (wr_strb[1]) begin
                    item_memory_num[ADDR_W-1:8] <= wr_data[ADDR_W-1:8];
                end
            end
        end
    end

    // unmapped offsets read zero
    always_ff @(posedge AXIS_ACLK) begin
        if (state == ST_AR1) begin
            S_AXI_RDATA <= '0;
            case (rd_offs)
                REG_CTRL:     S_AXI_RDATA[1:0] <= {run, gen};
                REG_ITEM_NUM: S_AXI_RDATA[ADDR_W-1:0] <= item_memory_num;
                default:      S_AXI_RDATA <= '0;
            endcase
        end
    end

    // one response channel active at a time
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(S_AXI_BVALID && S_AXI_RVALID));

endmodule

// ==== design/hdc_core.sv ====
`timescale 1ns/1ps

module hdc_core (
    input  logic                         AXIS_ACLK,
    input  logic                         S_AXI_ARESETN,
    input  logic                         item_we,
    input  logic [hdc_pkg::ADDR_W-1:0]   item_addr,
    input  logic [hdc_pkg::DIM-1:0]      item_vec,
    input  logic [hdc_pkg::FIELD_W-1:0]  field,
    input  logic                         beat_take,
    input  logic                         bundle_close,
    input  logic                         result_taken,
    output logic [hdc_pkg::DIM-1:0]      core_result
);
    import hdc_pkg::*;

    logic [DIM-1:0]     item_mem [2**ADDR_W];
    logic [DIM-1:0]     rd_vec;
    logic               take_d1;
    logic               close_d1;
    logic               close_d2;
    logic [COUNT_W-1:0] bit_cnt [DIM];
    logic [COUNT_W-1:0] beat_cnt;
    logic [DIM-1:0]     majority;

    // ---------------------------------------------------------
    // item memory
    // ---------------------------------------------------------

    // filled by item_gen during gen
    always_ff @(posedge AXIS_ACLK) begin
        if (item_we) begin
            item_mem[item_addr] <= item_vec;
        end
    end

    // read one cycle after the beat, low address bits only
    always_ff @(posedge AXIS_ACLK) begin
        if (beat_take) begin
            rd_vec <= item_mem[field[ADDR_W-1:0]];
        end
    end

    // beat and close markers follow the read
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            take_d1  <= 1'b0;
            close_d1 <= 1'b0;
            close_d2 <= 1'b0;
        end else begin
            take_d1  <= beat_take;
            close_d1 <= bundle_close;
            close_d2 <= close_d1;
        end
    end

    // ---------------------------------------------------------
    // bundling counters
    // ---------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        // cleared once the result is registered
        if (!S_AXI_ARESETN || close_d2) begin
            beat_cnt <= '0;
            for (int i = 0; i < DIM; i++) begin
                bit_cnt[i] <= '0;
            end
        end else if (take_d1) begin
            beat_cnt <= beat_cnt + 1'b1;
            // ones per bit position
            for (int i = 0; i < DIM; i++) begin
                bit_cnt[i] <= bit_cnt[i] + COUNT_W'(rd_vec[i]);
            end
        end
    end

    // strict majority, a tie gives 0
    always_comb begin
        for (int i = 0; i < DIM; i++) begin
            majority[i] = {bit_cnt[i], 1'b0} > {1'b0, beat_cnt};
        end
    end

    // ---------------------------------------------------------
    // result
    // ---------------------------------------------------------

    // held for the output beat, then cleared
    always_ff @(posedge AXIS_ACLK) begin
        if (close_d2) begin
            core_result <= majority;
        end else if (result_taken) begin
            core_result <= '0;
        end
    end

    // bit counts never pass the beat count, so this bounds every counter
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        take_d1 |-> beat_cnt != {COUNT_W{1'b1}});

endmodule

// ==== design/hdc_pkg.sv ====
package hdc_pkg;

    // ---------------------------------------------------------
    // hypervector and memory sizing
    // ---------------------------------------------------------

    // one generator word per hypervector
    localparam int DIM     = 32;
    // item memory depth is 2**ADDR_W, so item_memory_num tops out at 1023
    localparam int ADDR_W  = 10;
    // one core's slot in an input beat, low ADDR_W bits used
    localparam int FIELD_W = 16;
    // per-bit counters and beat counter, 255 beats max
    localparam int COUNT_W = 8;

    // ---------------------------------------------------------
    // control register map
    // ---------------------------------------------------------

    // decoded byte offset width
    localparam int AXIL_OFFS_W = 12;
    // bit 1 run, bit 0 gen
    localparam logic [AXIL_OFFS_W-1:0] REG_CTRL     = 12'h000;
    // item_memory_num in bits 9:0
    localparam logic [AXIL_OFFS_W-1:0] REG_ITEM_NUM = 12'h004;

    // ---------------------------------------------------------
    // xorshift generator
    // ---------------------------------------------------------

    // state held here whenever gen is low
    localparam logic [DIM-1:0] XORSHIFT_SEED = 32'h2463_534a;
    // shift amounts of one step
    localparam int XS_SHL_A = 13;
    localparam int XS_SHR_B = 17;
    localparam int XS_SHL_C = 5;

endpackage

// ==== design/hdc_top.sv ====
`timescale 1ns/1ps

module hdc_top #(
    parameter int NUM_CORES = 4
) (
    input  logic                                    AXIS_ACLK,
    input  logic                                    S_AXI_ARESETN,
    // axi-lite slave
    input  logic [31:0]                             S_AXI_AWADDR,
    input  logic                                    S_AXI_AWVALID,
    output logic                                    S_AXI_AWREADY,
    input  logic [31:0]                             S_AXI_WDATA,
    input  logic [3:0]                              S_AXI_WSTRB,
    input  logic                                    S_AXI_WVALID,
    output logic                                    S_AXI_WREADY,
    input  logic                                    S_AXI_BREADY,
    output logic [1:0]                              S_AXI_BRESP,
    output logic                                    S_AXI_BVALID,
    input  logic [31:0]                             S_AXI_ARADDR,
    input  logic                                    S_AXI_ARVALID,
    output logic                                    S_AXI_ARREADY,
    input  logic                                    S_AXI_RREADY,
    output logic [31:0]                             S_AXI_RDATA,
    output logic [1:0]                              S_AXI_RRESP,
    output logic                                    S_AXI_RVALID,
    // input stream, one address field per core
    input  logic [hdc_pkg::FIELD_W*NUM_CORES-1:0]   S_AXIS_TDATA,
    input  logic                                    S_AXIS_TVALID,
    input  logic                                    S_AXIS_TLAST,
    output logic                                    S_AXIS_TREADY,
    // output stream, core 0 in the low bits
    output logic [hdc_pkg::DIM*NUM_CORES-1:0]       M_AXIS_TDATA,
    output logic                                    M_AXIS_TVALID,
    output logic                                    M_AXIS_TLAST,
    input  logic                                    M_AXIS_TREADY
);
    import hdc_pkg::*;

    // control
    logic              run;
    logic              gen;
    logic              gen_done;
    logic [ADDR_W-1:0] item_memory_num;
    // item memory fill bus
    logic              item_we;
    logic [ADDR_W-1:0] item_addr;
    logic [DIM-1:0]    item_vec;
    // stream pulses
    logic              beat_take;
    logic              bundle_close;
    logic              result_taken;

    axil_regs u_regs (.*);

    item_gen u_gen (.*);

    stream_ctrl #(.NUM_CORES(NUM_CORES)) u_stream (.*);

    // one bundle, one beat
    assign M_AXIS_TLAST = M_AXIS_TVALID;

    // ---------------------------------------------------------
    // cores
    // ---------------------------------------------------------

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        hdc_core u_core (
            .AXIS_ACLK     (AXIS_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .item_we       (item_we),
            .item_addr     (item_addr),
            .item_vec      (item_vec),
            .field         (S_AXIS_TDATA[c*FIELD_W +: FIELD_W]),
            .beat_take     (beat_take),
            .bundle_close  (bundle_close),
            .result_taken  (result_taken),
            .core_result   (M_AXIS_TDATA[c*DIM +: DIM])
        );
    end

endmodule

// ==== design/item_gen.sv ====
`timescale 1ns/1ps

module item_gen (
    input  logic                        AXIS_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic                        gen,
    input  logic [hdc_pkg::ADDR_W-1:0]  item_memory_num,
    output logic                        item_we,
    output logic [hdc_pkg::ADDR_W-1:0]  item_addr,
    output logic [hdc_pkg::DIM-1:0]     item_vec,
    output logic                        gen_done
);
    import hdc_pkg::*;

    logic [DIM-1:0] xs_state;
    logic [DIM-1:0] xs_a;
    logic [DIM-1:0] xs_b;

    // ---------------------------------------------------------
    // xorshift step
    // ---------------------------------------------------------

    // left 13, right 17, left 5
    assign xs_a     = xs_state ^ (xs_state << XS_SHL_A);
    assign xs_b     = xs_a ^ (xs_a >> XS_SHR_B);
    // stepped value goes straight to the cores
    assign item_vec = xs_b ^ (xs_b << XS_SHL_C);

    // write every gen cycle except the done cycle
    assign item_we = gen && !gen_done;

    // ---------------------------------------------------------
    // address counter and done pulse
    // ---------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        // gen low parks the generator at the seed
        if (!S_AXI_ARESETN || !gen) begin
            xs_state  <= XORSHIFT_SEED;
            item_addr <= '0;
            gen_done  <= 1'b0;
        end else begin
            // last address just written
            gen_done <= item_we && (item_addr == item_memory_num);
            if (item_we) begin
                // item k holds state after k+1 steps
                xs_state  <= item_vec;
                item_addr <= item_addr + 1'b1;
            end
        end
    end

    // writes stay inside the configured range of a gen phase
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_we |-> gen && (item_addr <= item_memory_num));

endmodule

// ==== design/stream_ctrl.sv ====
`timescale 1ns/1ps

module stream_ctrl #(
    parameter int NUM_CORES = 4
) (
    input  logic AXIS_ACLK,
    input  logic S_AXI_ARESETN,
    input  logic run,
    input  logic gen,
    input  logic S_AXIS_TVALID,
    input  logic S_AXIS_TLAST,
    output logic S_AXIS_TREADY,
    input  logic M_AXIS_TREADY,
    output logic M_AXIS_TVALID,
    output logic beat_take,
    output logic bundle_close,
    output logic result_taken
);

    // set from tlast acceptance until output taken
    logic       busy;
    // close delayed to line up with the core result
    logic [1:0] close_pipe;

    // ---------------------------------------------------------
    // input side
    // ---------------------------------------------------------

    assign S_AXIS_TREADY = run && !gen && !busy;
    assign beat_take     = S_AXIS_TVALID && S_AXIS_TREADY;
    assign bundle_close  = beat_take && S_AXIS_TLAST;

    // ---------------------------------------------------------
    // output side
    // ---------------------------------------------------------

    assign result_taken = M_AXIS_TVALID && M_AXIS_TREADY;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy          <= 1'b0;
            close_pipe    <= 2'b00;
            M_AXIS_TVALID <= 1'b0;
        end else begin
            close_pipe <= {close_pipe[0], bundle_close};
            if (bundle_close) begin
                busy <= 1'b1;
            end else if (result_taken) begin
                busy <= 1'b0;
            end
            // tvalid 3 cycles after the tlast beat
            if (close_pipe[1]) begin
                M_AXIS_TVALID <= 1'b1;
            end else if (result_taken) begin
                M_AXIS_TVALID <= 1'b0;
            end
        end
    end

    // output beat held until taken
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        M_AXIS_TVALID && !M_AXIS_TREADY |=> M_AXIS_TVALID);

    // core count the 16-bit field layout was sized for
    assert property (@(posedge AXIS_ACLK)
        NUM_CORES >= 1 && NUM_CORES <= 16);

endmodule

// ==== testbench/tb_hdc_top.sv ====
`timescale 1ns/1ps

module tb_hdc_top;
    import hdc_pkg::*;

    localparam int NUM_CORES   = 4;
    localparam int NUM_BUNDLES = 12;
    localparam int MAX_BEATS   = 20;
    localparam int ITEM_NUM    = 63;
    // generous bound on beats plus the generation phase
    localparam int WATCHDOG_CYCLES = 20 * (NUM_BUNDLES * MAX_BEATS + ITEM_NUM);

    logic                           AXIS_ACLK;
    logic                           S_AXI_ARESETN;
    logic [31:0]                    S_AXI_AWADDR;
    logic                           S_AXI_AWVALID;
    logic                           S_AXI_AWREADY;
    logic [31:0]                    S_AXI_WDATA;
    logic [3:0]                     S_AXI_WSTRB;
    logic                           S_AXI_WVALID;
    logic                           S_AXI_WREADY;
    logic                           S_AXI_BREADY;
    logic [1:0]                     S_AXI_BRESP;
    logic                           S_AXI_BVALID;
    logic [31:0]                    S_AXI_ARADDR;
    logic                           S_AXI_ARVALID;
    logic                           S_AXI_ARREADY;
    logic                           S_AXI_RREADY;
    logic [31:0]                    S_AXI_RDATA;
    logic [1:0]                     S_AXI_RRESP;
    logic                           S_AXI_RVALID;
    logic [FIELD_W*NUM_CORES-1:0]   S_AXIS_TDATA;
    logic                           S_AXIS_TVALID;
    logic                           S_AXIS_TLAST;
    logic                           S_AXIS_TREADY;
    logic [DIM*NUM_CORES-1:0]       M_AXIS_TDATA;
    logic                           M_AXIS_TVALID;
    logic                           M_AXIS_TLAST;
    logic                           M_AXIS_TREADY;

    // model of the item memory, first ITEM_NUM+1 entries
    logic [DIM-1:0] exp_item [ITEM_NUM+1];
    // input ready may only be high when run is set and gen is clear
    logic           ready_allowed;
    // bundle closed, output not yet taken
    logic           hold_model;
    logic           tlast_acc;
    logic [31:0]    rd_word;
    int             len;

    hdc_top #(.NUM_CORES(NUM_CORES)) uut (.*);

    always #50 AXIS_ACLK = ~AXIS_ACLK;

    assign tlast_acc = S_AXIS_TVALID && S_AXIS_TREADY && S_AXIS_TLAST;

    always @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            hold_model <= 1'b0;
        end else if (tlast_acc) begin
            hold_model <= 1'b1;
        end else if (M_AXIS_TVALID && M_AXIS_TREADY) begin
            hold_model <= 1'b0;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
            else fail_run($sformatf("ERROR: %s got %h expected %h", name, got, exp));
    endtask

    // one xorshift step, shifts 13, 17, 5
    function automatic logic [31:0] xs_step(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ----------------------------------------------------------
    // axi-lite master
    // ----------------------------------------------------------

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge AXIS_ACLK);
        S_AXI_AWADDR  = addr;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WDATA   = data;
        S_AXI_WVALID  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge AXIS_ACLK);
            aw_done = aw_done || (S_AXI_AWVALID && S_AXI_AWREADY);
            w_done  = w_done || (S_AXI_WVALID && S_AXI_WREADY);
            @(negedge AXIS_ACLK);
            S_AXI_AWVALID = S_AXI_AWVALID && !aw_done;
            S_AXI_WVALID  = S_AXI_WVALID && !w_done;
        end
        // bready is tied high
        do @(posedge AXIS_ACLK); while (!S_AXI_BVALID);
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp);
        @(negedge AXIS_ACLK);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        do @(posedge AXIS_ACLK); while (!S_AXI_ARREADY);
        @(negedge AXIS_ACLK);
        S_AXI_ARVALID = 1'b0;
        do @(posedge AXIS_ACLK); while (!S_AXI_RVALID);
        rd_word = S_AXI_RDATA;
        check_value($sformatf("S_AXI_RDATA at %h", addr), rd_word, exp);
    endtask

    // ----------------------------------------------------------
    // one bundle in, one result beat out
    // ----------------------------------------------------------

    task automatic send_bundle(input int beats);
        int                     ones [NUM_CORES][DIM];
        logic [FIELD_W-1:0]     addr;
        logic [DIM*NUM_CORES-1:0] exp_out;
        logic                   taken;
        for (int c = 0; c < NUM_CORES; c++) begin
            for (int b = 0; b < DIM; b++) begin
                ones[c][b] = 0;
            end
        end
        for (int n = 0; n < beats; n++) begin
            @(negedge AXIS_ACLK);
            for (int c = 0; c < NUM_CORES; c++) begin
                addr = FIELD_W'($urandom % (ITEM_NUM + 1));
                S_AXIS_TDATA[c*FIELD_W +: FIELD_W] = addr;
                for (int b = 0; b < DIM; b++) begin
                    ones[c][b] += int'(exp_item[addr][b]);
                end
            end
            S_AXIS_TVALID = 1'b1;
            S_AXIS_TLAST  = (n == beats - 1);
            do @(posedge AXIS_ACLK); while (!S_AXIS_TREADY);
        end
        @(negedge AXIS_ACLK);
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        // strict majority, tie gives 0
        for (int c = 0; c < NUM_CORES; c++) begin
            for (int b = 0; b < DIM; b++) begin
                exp_out[c*DIM + b] = (2 * ones[c][b] > beats);
            end
        end
        // random back-pressure until the beat is taken
        taken = 1'b0;
        while (!taken) begin
            @(negedge AXIS_ACLK);
            M_AXIS_TREADY = $urandom % 2;
            @(posedge AXIS_ACLK);
            taken = M_AXIS_TVALID && M_AXIS_TREADY;
        end
        check_value("M_AXIS_TDATA", M_AXIS_TDATA, exp_out);
        @(negedge AXIS_ACLK);
        M_AXIS_TREADY = 1'b0;
    endtask

    // ----------------------------------------------------------
    // protocol checks
    // ----------------------------------------------------------

    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID |-> S_AXI_BRESP == 2'b00)
        else fail_run($sformatf("ERROR: S_AXI_BRESP got %h expected 0", S_AXI_BRESP));
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID |-> S_AXI_RRESP == 2'b00)
        else fail_run($sformatf("ERROR: S_AXI_RRESP got %h expected 0", S_AXI_RRESP));
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !ready_allowed |-> !S_AXIS_TREADY)
        else fail_run("S_AXIS_TREADY went high while run was clear or gen was set");
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        hold_model |-> !S_AXIS_TREADY)
        else fail_run("S_AXIS_TREADY went high before the output beat was taken");
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        M_AXIS_TVALID && !M_AXIS_TREADY |=> $stable(M_AXIS_TDATA))
        else fail_run($sformatf("ERROR: M_AXIS_TDATA changed while stalled, now %h",
                                M_AXIS_TDATA));
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        M_AXIS_TVALID |-> M_AXIS_TLAST)
        else fail_run($sformatf("ERROR: M_AXIS_TLAST got %h expected 1", M_AXIS_TLAST));
    // result exactly 3 cycles after tlast, and never without one
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        tlast_acc |-> ##3 $rose(M_AXIS_TVALID))
        else fail_run("M_AXIS_TVALID did not rise 3 cycles after the TLAST beat");
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(M_AXIS_TVALID) |-> $past(tlast_acc, 3))
        else fail_run("M_AXIS_TVALID rose without an accepted TLAST beat");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge AXIS_ACLK);
        $display("watchdog expired before the test sequence finished");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------

    initial begin
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = 4'hf;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b1;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        S_AXIS_TDATA  = '0;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        M_AXIS_TREADY = 1'b0;
        ready_allowed = 1'b0;
        void'($urandom(32'h0ff0_a934));
        // expected items, item k is the state after k+1 steps
        exp_item[0] = xs_step(32'h2463_534a);
        for (int k = 1; k <= ITEM_NUM; k++) begin
            exp_item[k] = xs_step(exp_item[k-1]);
        end
        repeat (3) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;
        check_value("S_AXIS_TREADY", S_AXIS_TREADY, 0);
        check_value("M_AXIS_TVALID", M_AXIS_TVALID, 0);
        check_value("S_AXI_AWREADY", S_AXI_AWREADY, 1);
        check_value("S_AXI_ARREADY", S_AXI_ARREADY, 1);

        // register read-back, unmapped offset reads zero
        axil_write(32'(REG_ITEM_NUM), 32'h0000_0155);
        check_read(32'(REG_ITEM_NUM), 32'h0000_0155);
        ready_allowed = 1'b1;
        axil_write(32'(REG_CTRL), 32'h0000_0002);
        check_read(32'(REG_CTRL), 32'h0000_0002);
        axil_write(32'(REG_CTRL), 32'h0000_0000);
        @(negedge AXIS_ACLK);
        ready_allowed = 1'b0;
        axil_write(32'h0000_0010, 32'hffff_ffff);
        check_read(32'h0000_0010, 32'h0000_0000);

        // generation with run already set, ready must stay low
        axil_write(32'(REG_ITEM_NUM), 32'(ITEM_NUM));
        check_read(32'(REG_ITEM_NUM), 32'(ITEM_NUM));
        axil_write(32'(REG_CTRL), 32'h0000_0003);
        // gen phase lasts item_memory_num+2 cycles from the ctrl write
        fork
            begin
                repeat (ITEM_NUM + 2) @(posedge AXIS_ACLK);
                ready_allowed = 1'b1;
            end
        join_none
        check_read(32'(REG_CTRL), 32'h0000_0003);
        repeat (ITEM_NUM + 2) @(posedge AXIS_ACLK);
        check_read(32'(REG_CTRL), 32'h0000_0002);
        check_read(32'(REG_CTRL), 32'h0000_0002);

        // random bundles with output back-pressure
        for (int i = 0; i < NUM_BUNDLES; i++) begin
            len = 1 + ($urandom % MAX_BEATS);
            send_bundle(len);
        end

        // run clear, offered beats go nowhere
        axil_write(32'(REG_CTRL), 32'h0000_0000);
        @(negedge AXIS_ACLK);
        ready_allowed = 1'b0;
        S_AXIS_TDATA  = (FIELD_W*NUM_CORES)'($urandom);
        S_AXIS_TVALID = 1'b1;
        S_AXIS_TLAST  = 1'b1;
        M_AXIS_TREADY = 1'b1;
        repeat (10) begin
            @(posedge AXIS_ACLK);
            check_value("M_AXIS_TVALID", M_AXIS_TVALID, 0);
        end
        @(negedge AXIS_ACLK);
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        M_AXIS_TREADY = 1'b0;
        repeat (5) @(posedge AXIS_ACLK);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
